/* l1_mau.f */
rtl/mau_pkg.sv
rtl/sync_fifo.sv
rtl/mau_req_arbiter.sv
rtl/mau_wb_issue.sv
rtl/mau_ack_collect.sv
rtl/l1_mau.sv
verif/mau_checker.sv
verif/tb_l1_mau.sv

/* rtl/l1_mau.sv */
`timescale 1ns/1ps

module l1_mau import mau_pkg::*; (
	input  logic       wb_clk_i,
	input  logic       wb_rst_i,

	// Instruction cache
	input  logic       l1i_req_val_i,
	input  core_addr_t l1i_req_addr_i,
	output logic       l1i_req_ack_o,
	output l1_line_t   l1i_ack_data_o,

	// Data cache
	input  logic       l1d_req_val_i,
	input  logic       l1d_req_nc_i,
	input  logic       l1d_req_we_i,
	input  core_addr_t l1d_req_addr_i,
	input  core_data_t l1d_req_wdata_i,
	input  core_be_t   l1d_req_be_i,
	output logic       l1d_req_ack_o,
	output l1_line_t   l1d_ack_data_o,
	output logic       l1d_ack_nc_o,
	output logic       l1d_ack_we_o,

	// Wishbone B4 pipelined master
	input  core_data_t wb_dat_i,
	input  logic       wb_ack_i,
	input  logic       wb_stall_i,
	output core_data_t wb_dat_o,
	output core_addr_t wb_adr_o,
	output logic       wb_cyc_o,
	output logic       wb_stb_o,
	output core_be_t   wb_sel_o,
	output logic       wb_we_o
);

	mau_req_hdr_t hdr_in;
	mau_req_hdr_t hdr_head;
	logic         hdr_push;
	logic         hdr_pop;
	logic         hdr_empty;
	logic         hdr_full;

	core_data_t   dat_in;
	core_data_t   dat_head;
	logic         dat_push;
	logic         dat_pop;
	logic         dat_full;

	mau_ack_tag_t tag_in;
	mau_ack_tag_t tag_head;
	logic         tag_push;
	logic         tag_pop;
	logic         tag_empty;
	logic         tag_full;

	logic         rd_done_i;
	logic         rd_done_d;
	logic         wr_ack;
	logic         wr_ack_nc;
	logic         rd_ack_d;
	logic         rd_ack_nc;
	l1_line_t     line;

	// ----------------------------------------
	// Queues
	// ----------------------------------------

	sync_fifo #(
		.DWIDTH ($bits(mau_req_hdr_t)),
		.AWIDTH (HDR_FIFO_AWIDTH)
	) u_hdr_fifo (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.push_i   (hdr_push),
		.pop_i    (hdr_pop),
		.wdata_i  (hdr_in),
		.rdata_o  (hdr_head),
		.empty_o  (hdr_empty),
		.full_o   (hdr_full)
	);

	sync_fifo #(
		.DWIDTH (CORE_DATA_WIDTH),
		.AWIDTH (DAT_FIFO_AWIDTH)
	) u_dat_fifo (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.push_i   (dat_push),
		.pop_i    (dat_pop),
		.wdata_i  (dat_in),
		.rdata_o  (dat_head),
		.empty_o  (),
		.full_o   (dat_full)
	);

	sync_fifo #(
		.DWIDTH ($bits(mau_ack_tag_t)),
		.AWIDTH (ACK_FIFO_AWIDTH)
	) u_tag_fifo (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.push_i   (tag_push),
		.pop_i    (tag_pop),
		.wdata_i  (tag_in),
		.rdata_o  (tag_head),
		.empty_o  (tag_empty),
		.full_o   (tag_full)
	);

	// ----------------------------------------
	// Pipeline stages
	// ----------------------------------------

	mau_req_arbiter u_arbiter (
		.wb_clk_i        (wb_clk_i),
		.wb_rst_i        (wb_rst_i),
		.l1i_req_val_i   (l1i_req_val_i),
		.l1i_req_addr_i  (l1i_req_addr_i),
		.l1d_req_val_i   (l1d_req_val_i),
		.l1d_req_nc_i    (l1d_req_nc_i),
		.l1d_req_we_i    (l1d_req_we_i),
		.l1d_req_addr_i  (l1d_req_addr_i),
		.l1d_req_wdata_i (l1d_req_wdata_i),
		.l1d_req_be_i    (l1d_req_be_i),
		.hdr_full_i      (hdr_full),
		.dat_full_i      (dat_full),
		.tag_full_i      (tag_full),
		.rd_done_i_i     (rd_done_i),
		.rd_done_d_i     (rd_done_d),
		.hdr_push_o      (hdr_push),
		.hdr_o           (hdr_in),
		.dat_push_o      (dat_push),
		.dat_o           (dat_in),
		.tag_push_o      (tag_push),
		.tag_o           (tag_in),
		.wr_ack_o        (wr_ack),
		.wr_ack_nc_o     (wr_ack_nc)
	);

	mau_wb_issue u_issue (
		.wb_clk_i    (wb_clk_i),
		.wb_rst_i    (wb_rst_i),
		.hdr_i       (hdr_head),
		.hdr_empty_i (hdr_empty),
		.hdr_pop_o   (hdr_pop),
		.dat_i       (dat_head),
		.dat_pop_o   (dat_pop),
		.wb_stall_i  (wb_stall_i),
		.wb_stb_o    (wb_stb_o),
		.wb_adr_o    (wb_adr_o),
		.wb_sel_o    (wb_sel_o),
		.wb_we_o     (wb_we_o),
		.wb_dat_o    (wb_dat_o)
	);

	mau_ack_collect u_collect (
		.wb_clk_i      (wb_clk_i),
		.wb_rst_i      (wb_rst_i),
		.wb_ack_i      (wb_ack_i),
		.wb_dat_i      (wb_dat_i),
		.tag_i         (tag_head),
		.tag_empty_i   (tag_empty),
		.tag_pop_o     (tag_pop),
		.rd_done_i_o   (rd_done_i),
		.rd_done_d_o   (rd_done_d),
		.line_o        (line),
		.l1i_req_ack_o (l1i_req_ack_o),
		.l1d_req_ack_o (rd_ack_d),
		.rd_ack_nc_o   (rd_ack_nc)
	);

	// Bus cycle spans every request still awaiting acknowledges
	assign wb_cyc_o = ~tag_empty;

	assign l1i_ack_data_o = line;
	assign l1d_ack_data_o = line;

	// Posted write and read return share the data cache outputs
	assign l1d_req_ack_o = wr_ack | rd_ack_d;
	assign l1d_ack_nc_o  = wr_ack_nc | rd_ack_nc;
	assign l1d_ack_we_o  = wr_ack;

endmodule

/* rtl/mau_ack_collect.sv */
`timescale 1ns/1ps

module mau_ack_collect import mau_pkg::*; (
	input  logic         wb_clk_i,
	input  logic         wb_rst_i,

	// Wishbone return side
	input  logic         wb_ack_i,
	input  core_data_t   wb_dat_i,

	// Tag FIFO
	input  mau_ack_tag_t tag_i,
	input  logic         tag_empty_i,
	output logic         tag_pop_o,

	// Outstanding-read release
	output logic         rd_done_i_o,
	output logic         rd_done_d_o,

	// Line and read acknowledges
	output l1_line_t     line_o,
	output logic         l1i_req_ack_o,
	output logic         l1d_req_ack_o,
	output logic         rd_ack_nc_o
);

	ack_state_e state_r;
	beat_cnt_t  cnt_r;
	beat_cnt_t  cnt_cur;
	logic       ack_v;
	logic       last_ack;
	l1_line_t   line_r;
	logic       done_r;
	mau_src_e   done_src_r;
	logic       done_nc_r;

	// ----------------------------------------
	// Beat counting
	// ----------------------------------------

	assign ack_v = wb_ack_i & ~tag_empty_i;

	// First acknowledge of a request takes its count from the head tag
	assign cnt_cur  = (state_r == ACK_IDLE) ? tag_i.last : cnt_r;
	assign last_ack = ack_v & (cnt_cur == '0);

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state_r <= ACK_IDLE;
			cnt_r   <= '0;
		end else if (ack_v) begin
			if (last_ack) begin
				state_r <= ACK_IDLE;
			end else begin
				state_r <= ACK_REC;
				cnt_r   <= cnt_cur - 1'b1;
			end
		end
	end

	assign tag_pop_o = last_ack;

	// ----------------------------------------
	// Line assembly and read acknowledge
	// ----------------------------------------

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			line_r <= '0;
		end else if (ack_v && !tag_i.we) begin
			line_r <= {wb_dat_i, line_r[L1_LINE_SIZE-1:CORE_DATA_WIDTH]};
		end
	end

	// Write tags retire without a pulse
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			done_r <= 1'b0;
		end else begin
			done_r <= last_ack & ~tag_i.we;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (last_ack) begin
			done_src_r <= tag_i.src;
			done_nc_r  <= tag_i.nc;
		end
	end

	assign line_o        = line_r;
	assign l1i_req_ack_o = done_r & (done_src_r == MAU_SRC_I);
	assign l1d_req_ack_o = done_r & (done_src_r == MAU_SRC_D);
	assign rd_ack_nc_o   = done_r & done_nc_r;
	assign rd_done_i_o   = l1i_req_ack_o;
	assign rd_done_d_o   = l1d_req_ack_o;

	// Slave acknowledges only beats that were issued
	a_ack_tagged: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_ack_i |-> !tag_empty_i)
		else $error("collector: acknowledge with no request in flight");

endmodule

/* rtl/mau_pkg.sv */
package mau_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------

	localparam int CORE_ADDR_WIDTH = 32;
	localparam int CORE_DATA_WIDTH = 32;
	localparam int CORE_BE_WIDTH   = 4;
	localparam int L1_LINE_SIZE    = 128;

	// Beats in one cache line and the byte step between them
	localparam int BEATS_PER_LINE = L1_LINE_SIZE / CORE_DATA_WIDTH;
	localparam int BEAT_ADDR_STEP = CORE_DATA_WIDTH / 8;

	// FIFO address widths
	localparam int HDR_FIFO_AWIDTH = 2;
	localparam int DAT_FIFO_AWIDTH = 1;
	localparam int ACK_FIFO_AWIDTH = 2;

	// ----------------------------------------
	// Types
	// ----------------------------------------

	typedef logic [CORE_ADDR_WIDTH-1:0]        core_addr_t;
	typedef logic [CORE_DATA_WIDTH-1:0]        core_data_t;
	typedef logic [CORE_BE_WIDTH-1:0]          core_be_t;
	typedef logic [L1_LINE_SIZE-1:0]           l1_line_t;
	typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt_t;

	typedef enum logic {
		MAU_SRC_I = 1'b0,
		MAU_SRC_D = 1'b1
	} mau_src_e;

	typedef enum logic {
		TR_IDLE = 1'b0,
		TR_REQ  = 1'b1
	} tr_state_e;

	typedef enum logic {
		ACK_IDLE = 1'b0,
		ACK_REC  = 1'b1
	} ack_state_e;

	// Bus request as queued for the issue stage
	typedef struct packed {
		logic       we;
		logic       nc;
		core_be_t   be;
		core_addr_t addr;
	} mau_req_hdr_t;

	// Return bookkeeping, one per accepted request
	typedef struct packed {
		mau_src_e  src;
		logic      we;
		logic      nc;
		beat_cnt_t last;
	} mau_ack_tag_t;

endpackage

/* rtl/mau_req_arbiter.sv */
`timescale 1ns/1ps

module mau_req_arbiter import mau_pkg::*; (
	input  logic         wb_clk_i,
	input  logic         wb_rst_i,

	// Instruction cache
	input  logic         l1i_req_val_i,
	input  core_addr_t   l1i_req_addr_i,

	// Data cache
	input  logic         l1d_req_val_i,
	input  logic         l1d_req_nc_i,
	input  logic         l1d_req_we_i,
	input  core_addr_t   l1d_req_addr_i,
	input  core_data_t   l1d_req_wdata_i,
	input  core_be_t     l1d_req_be_i,

	// FIFO status
	input  logic         hdr_full_i,
	input  logic         dat_full_i,
	input  logic         tag_full_i,

	// Reads retired by the collector
	input  logic         rd_done_i_i,
	input  logic         rd_done_d_i,

	// FIFO writes
	output logic         hdr_push_o,
	output mau_req_hdr_t hdr_o,
	output logic         dat_push_o,
	output core_data_t   dat_o,
	output logic         tag_push_o,
	output mau_ack_tag_t tag_o,

	// Posted write acknowledge
	output logic         wr_ack_o,
	output logic         wr_ack_nc_o
);

	logic i_rd_pend_r;
	logic d_rd_pend_r;
	logic room;
	logic d_acc;
	logic i_acc;
	logic d_wr;

	// ----------------------------------------
	// Acceptance
	// ----------------------------------------

	assign room  = ~hdr_full_i & ~tag_full_i;
	assign d_acc = l1d_req_val_i & room & (~l1d_req_we_i | ~dat_full_i) & ~d_rd_pend_r;

	// Instruction side yields to any data request not yet taken as a read
	assign i_acc = l1i_req_val_i & room & ~i_rd_pend_r & (~l1d_req_val_i | d_rd_pend_r);

	assign d_wr = d_acc & l1d_req_we_i;

	// A held read must not be accepted a second time
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			d_rd_pend_r <= 1'b0;
			i_rd_pend_r <= 1'b0;
		end else begin
			if (d_acc && !l1d_req_we_i) begin
				d_rd_pend_r <= 1'b1;
			end else if (rd_done_d_i) begin
				d_rd_pend_r <= 1'b0;
			end
			if (i_acc) begin
				i_rd_pend_r <= 1'b1;
			end else if (rd_done_i_i) begin
				i_rd_pend_r <= 1'b0;
			end
		end
	end

	// ----------------------------------------
	// Header, data and tag
	// ----------------------------------------

	assign hdr_push_o = d_acc | i_acc;
	assign hdr_o.we   = d_wr;
	assign hdr_o.nc   = d_acc & l1d_req_nc_i;
	assign hdr_o.be   = d_acc ? l1d_req_be_i : '1;
	assign hdr_o.addr = d_acc ? l1d_req_addr_i : l1i_req_addr_i;

	assign dat_push_o = d_wr;
	assign dat_o      = l1d_req_wdata_i;

	assign tag_push_o = d_acc | i_acc;
	assign tag_o.src  = d_acc ? MAU_SRC_D : MAU_SRC_I;
	assign tag_o.we   = d_wr;
	assign tag_o.nc   = d_acc & l1d_req_nc_i;
	// Single beat for writes and uncached reads
	assign tag_o.last = (d_acc & (l1d_req_nc_i | l1d_req_we_i)) ? '0 :
	                    beat_cnt_t'(BEATS_PER_LINE - 1);

	assign wr_ack_o    = d_wr;
	assign wr_ack_nc_o = d_wr & l1d_req_nc_i;

	a_one_accept: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		!(d_acc && i_acc))
		else $error("arbiter: two requests accepted in one cycle");

	a_room: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		hdr_push_o |-> !hdr_full_i && !tag_full_i && !(dat_push_o && dat_full_i))
		else $error("arbiter: accepted into a full FIFO");

	// Collector only retires reads this side has outstanding
	a_done_pending: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		(rd_done_d_i |-> d_rd_pend_r) and (rd_done_i_i |-> i_rd_pend_r))
		else $error("arbiter: read done without an outstanding read");

endmodule

/* rtl/mau_wb_issue.sv */
`timescale 1ns/1ps

module mau_wb_issue import mau_pkg::*; (
	input  logic         wb_clk_i,
	input  logic         wb_rst_i,

	// Header FIFO
	input  mau_req_hdr_t hdr_i,
	input  logic         hdr_empty_i,
	output logic         hdr_pop_o,

	// Write-data FIFO
	input  core_data_t   dat_i,
	output logic         dat_pop_o,

	// Wishbone master request side
	input  logic         wb_stall_i,
	output logic         wb_stb_o,
	output core_addr_t   wb_adr_o,
	output core_be_t     wb_sel_o,
	output logic         wb_we_o,
	output core_data_t   wb_dat_o
);

	tr_state_e  state_r;
	core_addr_t addr_r;
	beat_cnt_t  cnt_r;
	logic       line_rd;
	logic       beat_taken;
	logic       final_beat;

	assign line_rd    = ~hdr_i.we & ~hdr_i.nc;
	assign beat_taken = (state_r == TR_REQ) & ~wb_stall_i;
	assign final_beat = beat_taken & (cnt_r == '0);

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state_r <= TR_IDLE;
			addr_r  <= '0;
			cnt_r   <= '0;
		end else begin
			case (state_r)
				TR_IDLE: begin
					if (!hdr_empty_i) begin
						state_r <= TR_REQ;
						addr_r  <= hdr_i.addr;
						cnt_r   <= line_rd ? beat_cnt_t'(BEATS_PER_LINE - 1) : '0;
					end
				end
				TR_REQ: begin
					// Beat advances only once the slave takes it
					if (final_beat) begin
						state_r <= TR_IDLE;
					end else if (beat_taken) begin
						addr_r <= addr_r + core_addr_t'(BEAT_ADDR_STEP);
						cnt_r  <= cnt_r - 1'b1;
					end
				end
				default: begin
					state_r <= TR_IDLE;
				end
			endcase
		end
	end

	// Header leaves the FIFO with its final beat
	assign hdr_pop_o = final_beat;
	assign dat_pop_o = final_beat & hdr_i.we;

	assign wb_stb_o = (state_r == TR_REQ);
	assign wb_adr_o = addr_r;
	assign wb_sel_o = line_rd ? '1 : hdr_i.be;
	assign wb_we_o  = wb_stb_o & hdr_i.we;
	assign wb_dat_o = dat_i;

	a_stall_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_stb_o && wb_stall_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o))
		else $error("issue: beat changed under stall");

	a_hdr_held: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_stb_o |-> !hdr_empty_i)
		else $error("issue: strobe without a queued header");

endmodule

/* rtl/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
	parameter int DWIDTH = 32,
	parameter int AWIDTH = 2
) (
	input  logic              wb_clk_i,
	input  logic              wb_rst_i,
	input  logic              push_i,
	input  logic              pop_i,
	input  logic [DWIDTH-1:0] wdata_i,
	output logic [DWIDTH-1:0] rdata_o,
	output logic              empty_o,
	output logic              full_o
);

	logic [DWIDTH-1:0] mem [2**AWIDTH];

	// Extra top bit tells a full buffer from an empty one
	logic [AWIDTH:0] wr_ptr_r;
	logic [AWIDTH:0] rd_ptr_r;

	assign empty_o = (wr_ptr_r == rd_ptr_r);
	assign full_o  = (wr_ptr_r[AWIDTH-1:0] == rd_ptr_r[AWIDTH-1:0]) &&
	                 (wr_ptr_r[AWIDTH] != rd_ptr_r[AWIDTH]);

	// Head word is visible without a read cycle
	assign rdata_o = mem[rd_ptr_r[AWIDTH-1:0]];

	always_ff @(posedge wb_clk_i) begin
		if (push_i) begin
			mem[wr_ptr_r[AWIDTH-1:0]] <= wdata_i;
		end
	end

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_r <= wr_ptr_r + 1'b1;
			end
			if (pop_i) begin
				rd_ptr_r <= rd_ptr_r + 1'b1;
			end
		end
	end

	// Producers and consumers must honour the flags
	a_no_overflow: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		push_i |-> !full_o)
		else $error("sync_fifo: push while full");

	a_no_underflow: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		pop_i |-> !empty_o)
		else $error("sync_fifo: pop while empty");

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_l1_mau -f l1_mau.f -o sim_l1_mau > build.log 2>&1 \
	&& ./obj_dir/sim_l1_mau > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "Regression passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* verif/mau_checker.sv */
`timescale 1ns/1ps

module mau_checker import mau_pkg::*; (
	input  logic       wb_clk_i,
	input  logic       wb_rst_i,

	// Instruction cache side
	input  core_addr_t l1i_addr_i,
	input  logic       l1i_ack_i,
	input  l1_line_t   l1i_data_i,

	// Data cache side
	input  core_addr_t l1d_addr_i,
	input  logic       l1d_nc_i,
	input  logic       l1d_we_i,
	input  logic       l1d_ack_i,
	input  l1_line_t   l1d_data_i,
	input  logic       l1d_ack_nc_i,
	input  logic       l1d_ack_we_i,

	// Running totals for the test sequence
	output int         errors_o,
	output int         i_acks_o,
	output int         d_rd_acks_o,
	output int         wr_acks_o
);

	int err_cnt    = 0;
	int i_ack_cnt  = 0;
	int d_ack_cnt  = 0;
	int wr_ack_cnt = 0;

	assign errors_o    = err_cnt;
	assign i_acks_o    = i_ack_cnt;
	assign d_rd_acks_o = d_ack_cnt;
	assign wr_acks_o   = wr_ack_cnt;

	// Slave answers a read with the address, upper half inverted
	function automatic core_data_t expected_word(input core_addr_t addr);
		return {~addr[31:16], addr[15:0]};
	endfunction

	// Beat 0 of a line lands in the lowest word
	function automatic l1_line_t ref_line(input core_addr_t addr, input logic nc);
		l1_line_t line;
		line = '0;
		if (nc) begin
			line[L1_LINE_SIZE-1 -: CORE_DATA_WIDTH] = expected_word(addr);
		end else begin
			for (int k = 0; k < BEATS_PER_LINE; k++) begin
				line[k*CORE_DATA_WIDTH +: CORE_DATA_WIDTH] =
					expected_word(addr + core_addr_t'(k * BEAT_ADDR_STEP));
			end
		end
		return line;
	endfunction

	task automatic compare(input string sig, input l1_line_t got, input l1_line_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s expected %h got %h", $time, sig, exp, got);
			err_cnt++;
		end
	endtask

	// ----------------------------------------
	// Compare at every acknowledge
	// ----------------------------------------

	always @(negedge wb_clk_i) begin
		l1_line_t exp_line;
		if (!wb_rst_i) begin
			if (l1i_ack_i) begin
				i_ack_cnt++;
				compare("l1i_ack_data_o", l1i_data_i, ref_line(l1i_addr_i, 1'b0));
			end
			if (l1d_ack_we_i) begin
				wr_ack_cnt++;
				if (!l1d_we_i) begin
					$display("write acknowledge at %0t without a write request", $time);
					err_cnt++;
				end
				compare("l1d_req_ack_o", l1_line_t'(l1d_ack_i), l1_line_t'(1'b1));
				compare("l1d_ack_nc_o", l1_line_t'(l1d_ack_nc_i), l1_line_t'(l1d_nc_i));
			end else if (l1d_ack_i) begin
				d_ack_cnt++;
				exp_line = ref_line(l1d_addr_i, l1d_nc_i);
				compare("l1d_ack_nc_o", l1_line_t'(l1d_ack_nc_i), l1_line_t'(l1d_nc_i));
				if (l1d_nc_i) begin
					// Only the top word is defined for a single beat
					compare("l1d_ack_data_o[127:96]",
						l1_line_t'(l1d_data_i[L1_LINE_SIZE-1 -: CORE_DATA_WIDTH]),
						l1_line_t'(exp_line[L1_LINE_SIZE-1 -: CORE_DATA_WIDTH]));
				end else begin
					compare("l1d_ack_data_o", l1d_data_i, exp_line);
				end
			end
		end
	end

endmodule

/* verif/tb_l1_mau.sv */
`timescale 1ns/1ps

module tb_l1_mau import mau_pkg::*; ();

	localparam int WAIT_LIMIT = 300;

	typedef struct packed {
		core_addr_t adr;
		core_be_t   sel;
		logic       we;
		core_data_t dat;
	} beat_t;

	typedef struct packed {
		core_addr_t adr;
		logic       we;
		int         ready;
	} pend_t;

	logic       wb_clk_i        = 1'b0;
	logic       wb_rst_i        = 1'b1;
	logic       l1i_req_val_i   = 1'b0;
	core_addr_t l1i_req_addr_i  = '0;
	logic       l1d_req_val_i   = 1'b0;
	logic       l1d_req_nc_i    = 1'b0;
	logic       l1d_req_we_i    = 1'b0;
	core_addr_t l1d_req_addr_i  = '0;
	core_data_t l1d_req_wdata_i = '0;
	core_be_t   l1d_req_be_i    = '0;
	core_data_t wb_dat_i        = '0;
	logic       wb_ack_i        = 1'b0;
	logic       wb_stall_i      = 1'b0;

	logic       l1i_req_ack_o;
	l1_line_t   l1i_ack_data_o;
	logic       l1d_req_ack_o;
	l1_line_t   l1d_ack_data_o;
	logic       l1d_ack_nc_o;
	logic       l1d_ack_we_o;
	core_data_t wb_dat_o;
	core_addr_t wb_adr_o;
	logic       wb_cyc_o;
	logic       wb_stb_o;
	core_be_t   wb_sel_o;
	logic       wb_we_o;

	int chk_errors;
	int chk_i_acks;
	int chk_d_acks;
	int chk_wr_acks;

	beat_t       beat_log[$];
	pend_t       pend_q[$];
	int          cycle_cnt = 0;
	logic [15:0] lfsr_q    = 16'd48;
	logic [3:0]  dly_next  = '0;

	int err_cnt      = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int err_base;
	int i_base;
	int d_base;
	int w_base;

	always #2 wb_clk_i = ~wb_clk_i;

	l1_mau dut0 (.*);

	mau_checker chk0 (
		.wb_clk_i     (wb_clk_i),
		.wb_rst_i     (wb_rst_i),
		.l1i_addr_i   (l1i_req_addr_i),
		.l1i_ack_i    (l1i_req_ack_o),
		.l1i_data_i   (l1i_ack_data_o),
		.l1d_addr_i   (l1d_req_addr_i),
		.l1d_nc_i     (l1d_req_nc_i),
		.l1d_we_i     (l1d_req_we_i),
		.l1d_ack_i    (l1d_req_ack_o),
		.l1d_data_i   (l1d_ack_data_o),
		.l1d_ack_nc_i (l1d_ack_nc_o),
		.l1d_ack_we_i (l1d_ack_we_o),
		.errors_o     (chk_errors),
		.i_acks_o     (chk_i_acks),
		.d_rd_acks_o  (chk_d_acks),
		.wr_acks_o    (chk_wr_acks)
	);

	// ----------------------------------------
	// Random bits and Wishbone slave
	// ----------------------------------------

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [3:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[2:0], lfsr_q[0]};
		end
	endtask

	function automatic core_data_t slave_word(input core_addr_t addr);
		return {~addr[31:16], addr[15:0]};
	endfunction

	// Drive stall and in-order acknowledges
	always @(posedge wb_clk_i) begin
		logic [3:0] r;
		#1;
		cycle_cnt++;
		take_bits(2, r);
		wb_stall_i = (r[1:0] == 2'b11) && !wb_rst_i;
		take_bits(2, r);
		dly_next = r;
		if (!wb_rst_i && pend_q.size() > 0 && pend_q[0].ready <= cycle_cnt) begin
			wb_ack_i = 1'b1;
			wb_dat_i = pend_q[0].we ? '0 : slave_word(pend_q[0].adr);
		end else begin
			wb_ack_i = 1'b0;
			wb_dat_i = '0;
		end
	end

	// Beats taken and acknowledges delivered in this cycle
	always @(negedge wb_clk_i) begin
		beat_t b;
		pend_t p;
		if (!wb_rst_i) begin
			if (wb_ack_i && pend_q.size() > 0) begin
				pend_q.delete(0);
			end
			if (wb_stb_o && !wb_stall_i) begin
				b.adr = wb_adr_o;
				b.sel = wb_sel_o;
				b.we  = wb_we_o;
				b.dat = wb_dat_o;
				beat_log.push_back(b);
				p.adr   = wb_adr_o;
				p.we    = wb_we_o;
				p.ready = cycle_cnt + 1 + int'(dly_next);
				pend_q.push_back(p);
			end
		end
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	task automatic next_cycle();
		@(posedge wb_clk_i);
		#1;
	endtask

	task automatic check_value(input string sig, input l1_line_t got, input l1_line_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s expected %h got %h", $time, sig, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_count(input string sig, input int got, input int exp);
		if (got != exp) begin
			$display("error at %0t: %s expected %0d got %0d", $time, sig, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_beat(input int idx, input core_addr_t adr, input core_be_t sel,
			input logic we, input core_data_t dat);
		if (idx >= beat_log.size()) begin
			$display("bus beat %0d for address %h was never issued", idx, adr);
			err_cnt++;
		end else begin
			check_value("wb_adr_o", l1_line_t'(beat_log[idx].adr), l1_line_t'(adr));
			check_value("wb_sel_o", l1_line_t'(beat_log[idx].sel), l1_line_t'(sel));
			check_value("wb_we_o", l1_line_t'(beat_log[idx].we), l1_line_t'(we));
			if (we) begin
				check_value("wb_dat_o", l1_line_t'(beat_log[idx].dat), l1_line_t'(dat));
			end
		end
	endtask

	task automatic check_line_beats(input int first, input core_addr_t base);
		for (int k = 0; k < BEATS_PER_LINE; k++) begin
			check_beat(first + k, base + core_addr_t'(k * BEAT_ADDR_STEP), 4'hf, 1'b0, '0);
		end
	endtask

	task automatic wait_bus_idle();
		int n;
		n = 0;
		while ((wb_cyc_o || wb_stb_o) && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			$display("timeout at %0t: bus cycle never ended", $time);
			err_cnt++;
		end
		// Room for a stray second acknowledge to show up
		repeat (4) next_cycle();
	endtask

	task automatic read_i(input core_addr_t addr);
		int n;
		l1i_req_addr_i = addr;
		l1i_req_val_i  = 1'b1;
		n = 0;
		do begin
			next_cycle();
			n++;
		end while (!l1i_req_ack_o && n < WAIT_LIMIT);
		l1i_req_val_i = 1'b0;
		if (!l1i_req_ack_o) begin
			$display("timeout at %0t: no instruction acknowledge for %h", $time, addr);
			err_cnt++;
		end
	endtask

	task automatic read_d(input core_addr_t addr, input logic nc);
		int n;
		l1d_req_addr_i = addr;
		l1d_req_nc_i   = nc;
		l1d_req_we_i   = 1'b0;
		l1d_req_be_i   = 4'hf;
		l1d_req_val_i  = 1'b1;
		n = 0;
		do begin
			next_cycle();
			n++;
		end while (!l1d_req_ack_o && n < WAIT_LIMIT);
		l1d_req_val_i = 1'b0;
		if (!l1d_req_ack_o) begin
			$display("timeout at %0t: no data acknowledge for %h", $time, addr);
			err_cnt++;
		end
	endtask

	// Bus is idle, so the write must be taken in its first cycle
	task automatic write_d(input core_addr_t addr, input core_be_t be, input core_data_t data,
			input logic nc);
		l1d_req_addr_i  = addr;
		l1d_req_be_i    = be;
		l1d_req_wdata_i = data;
		l1d_req_nc_i    = nc;
		l1d_req_we_i    = 1'b1;
		l1d_req_val_i   = 1'b1;
		@(negedge wb_clk_i);
		check_value("l1d_req_ack_o", l1_line_t'(l1d_req_ack_o), l1_line_t'(1'b1));
		check_value("l1d_ack_we_o", l1_line_t'(l1d_ack_we_o), l1_line_t'(1'b1));
		next_cycle();
		l1d_req_val_i = 1'b0;
		l1d_req_we_i  = 1'b0;
	endtask

	task automatic start_test();
		err_base = err_cnt + chk_errors;
		i_base   = chk_i_acks;
		d_base   = chk_d_acks;
		w_base   = chk_wr_acks;
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = err_cnt + chk_errors - err_base;
		tests_run++;
		if (errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errs);
		end
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------

	initial begin
		int first;
		repeat (3) @(posedge wb_clk_i);
		#1;
		wb_rst_i = 1'b0;

		start_test();
		for (int k = 0; k < 8; k++) begin
			@(negedge wb_clk_i);
			check_value("wb_cyc_o", l1_line_t'(wb_cyc_o), '0);
			check_value("wb_stb_o", l1_line_t'(wb_stb_o), '0);
			check_value("l1i_req_ack_o", l1_line_t'(l1i_req_ack_o), '0);
			check_value("l1d_req_ack_o", l1_line_t'(l1d_req_ack_o), '0);
			check_value("l1i_ack_data_o", l1i_ack_data_o, '0);
		end
		next_cycle();
		end_test("reset");

		start_test();
		first = beat_log.size();
		read_i(32'h0000_1040);
		wait_bus_idle();
		check_count("bus beats", beat_log.size() - first, BEATS_PER_LINE);
		check_line_beats(first, 32'h0000_1040);
		check_count("l1i_req_ack_o pulses", chk_i_acks - i_base, 1);
		end_test("instruction line fetch");

		start_test();
		read_d(32'h8000_2a30, 1'b0);
		wait_bus_idle();
		read_d(32'h1234_5670, 1'b0);
		wait_bus_idle();
		read_d(32'hfedc_ba90, 1'b0);
		wait_bus_idle();
		check_count("l1d_req_ack_o pulses", chk_d_acks - d_base, 3);
		end_test("data line read");

		start_test();
		first = beat_log.size();
		read_d(32'h4000_0124, 1'b1);
		wait_bus_idle();
		check_count("bus beats", beat_log.size() - first, 1);
		check_beat(first, 32'h4000_0124, 4'hf, 1'b0, '0);
		check_count("l1d_req_ack_o pulses", chk_d_acks - d_base, 1);
		end_test("uncached read");

		start_test();
		first = beat_log.size();
		write_d(32'h2000_0010, 4'b0110, 32'h1234_5678, 1'b0);
		wait_bus_idle();
		check_count("bus beats", beat_log.size() - first, 1);
		check_beat(first, 32'h2000_0010, 4'b0110, 1'b1, 32'h1234_5678);
		first = beat_log.size();
		write_d(32'h2000_0104, 4'hf, 32'hcafe_f00d, 1'b1);
		wait_bus_idle();
		check_count("bus beats", beat_log.size() - first, 1);
		check_beat(first, 32'h2000_0104, 4'hf, 1'b1, 32'hcafe_f00d);
		check_count("write acknowledges", chk_wr_acks - w_base, 2);
		check_count("read acknowledges", chk_d_acks - d_base + chk_i_acks - i_base, 0);
		end_test("posted writes");

		start_test();
		first = beat_log.size();
		fork
			read_i(32'h0000_3000);
			read_d(32'h0000_5010, 1'b0);
		join
		wait_bus_idle();
		check_count("bus beats", beat_log.size() - first, 2 * BEATS_PER_LINE);
		check_line_beats(first, 32'h0000_5010);
		check_line_beats(first + BEATS_PER_LINE, 32'h0000_3000);
		check_count("l1i_req_ack_o pulses", chk_i_acks - i_base, 1);
		check_count("l1d_req_ack_o pulses", chk_d_acks - d_base, 1);
		end_test("simultaneous reads");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			err_cnt + chk_errors);
		if (tests_failed == 0 && err_cnt + chk_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
